//--- verilog/icache_cfg_pkg.sv
package icache_cfg_pkg;

    // Total cache size and block size in bytes.
    localparam int CACHE_BYTES = 1024;
    localparam int BLOCK_BYTES = 16;

    localparam int BLOCK_WORDS = BLOCK_BYTES / 4;  // Instructions per block.

    // Word select within a block.
    localparam int OFFSET_W = $clog2(BLOCK_WORDS);

    localparam int LINES = CACHE_BYTES / BLOCK_BYTES;  // Direct mapped, one block per line.
    localparam int INDEX_W = $clog2(LINES);

    // Remaining address bits above byte, word and line select.
    localparam int TAG_W = 32 - 2 - OFFSET_W - INDEX_W;

endpackage : icache_cfg_pkg

//--- verilog/icache_types_pkg.sv
package icache_types_pkg;

    import icache_cfg_pkg::*;

    typedef logic [31:0] instr_t;

    // Word 0 sits in the low bits, the same order as ascending addresses.
    typedef instr_t [BLOCK_WORDS-1:0] block_t;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // One line as written into the array by a refill.
    typedef struct packed {
        index_t index;
        tag_t   tag;
        block_t block;
    } line_write_t;

endpackage : icache_types_pkg

//--- verilog/icache_if.sv
interface bundle_if import icache_types_pkg::*; ();

    logic        req;
    logic [31:0] addr;        // Address of the wanted word.
    logic        ready;
    block_t      bundle;
    logic        miss;
    logic        invalidate;

    // The array answers hits, the refill controller answers misses.
    logic   hit_ready;
    block_t hit_bundle;
    logic   fill_ready;
    block_t fill_bundle;

    assign ready  = hit_ready | fill_ready;
    assign bundle = fill_ready ? fill_bundle : hit_bundle;

    modport requester (output req, addr, invalidate, input ready, bundle);

    modport responder (
        input  req, addr, invalidate, ready,
        output hit_ready, hit_bundle, miss
    );

    modport refill (input addr, miss, output fill_ready, fill_bundle);

endinterface : bundle_if


interface line_write_if import icache_types_pkg::*; ();

    logic   we;     // Single cycle, marks the line valid.
    index_t index;
    tag_t   tag;
    block_t block;

    modport source (output we, index, tag, block);

    modport sink (input we, index, tag, block);

endinterface : line_write_if

//--- verilog/fetch_sequencer.sv
module fetch_sequencer import icache_cfg_pkg::*, icache_types_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_i,
    input  logic [31:0] fetch_addr_i,
    input  logic        invalidate_i,
    output instr_t      instr_o,
    output logic        valid_o,
    output logic        stall_o,

    bundle_if.requester bus_o
);

    logic [31:0] prev_addr_q;  // Last delivered address.
    logic [31:0] addr_q;
    logic        req_q;

    // Words that follow the last delivered one, next word at index 0.
    instr_t [BLOCK_WORDS-2:0] word_buf_q;
    offset_t                  word_cnt_q;

    offset_t word_off;
    logic    seq_hit;
    logic    issue;
    block_t  rest;

    assign word_off = fetch_addr_i[2 +: OFFSET_W];

    // Sequential and still buffered, answer at once.
    assign seq_hit = fetch_i && !req_q && (word_cnt_q != '0)
                  && (fetch_addr_i == prev_addr_q + 32'd4);

    assign issue = fetch_i && !seq_hit && !req_q;  // Jump or empty buffer.

    // Block with the words after the delivered one moved down to index 0.
    assign rest = bus_o.bundle >> (32 * (int'(word_off) + 1));

    assign valid_o = seq_hit || bus_o.ready;
    assign stall_o = fetch_i && !valid_o;
    assign instr_o = bus_o.ready ? bus_o.bundle[word_off] : word_buf_q[0];

    assign bus_o.req        = req_q;
    assign bus_o.addr       = addr_q;
    assign bus_o.invalidate = invalidate_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q <= 1'b0;
        end else if (bus_o.ready) begin
            req_q <= 1'b0;
        end else if (issue) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            addr_q <= fetch_addr_i;  // Held until the block returns.
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prev_addr_q <= '0;
            word_cnt_q  <= '0;
        end else if (invalidate_i) begin
            word_cnt_q <= '0;
        end else if (bus_o.ready) begin
            prev_addr_q <= fetch_addr_i;
            word_cnt_q  <= offset_t'(BLOCK_WORDS - 1) - word_off;
        end else if (seq_hit) begin
            prev_addr_q <= fetch_addr_i;
            word_cnt_q  <= word_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_o.ready) begin
            word_buf_q <= rest[BLOCK_WORDS-2:0];
        end else if (seq_hit) begin
            // Shift towards index 0.
            word_buf_q <= {32'h0, word_buf_q[BLOCK_WORDS-2:1]};
        end
    end

    // The array and refill side rely on a steady request.
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus_o.req && !bus_o.ready |=> bus_o.req && $stable(bus_o.addr));

endmodule : fetch_sequencer

//--- verilog/icache_array.sv
module icache_array import icache_cfg_pkg::*, icache_types_pkg::*; (
    input logic clk_i,
    input logic rst_n_i,

    bundle_if.responder bus_i,
    line_write_if.sink  fill_i
);

    logic [LINES-1:0] valid_q;
    tag_t             tag_mem [LINES];
    block_t           data_mem [LINES];

    logic busy_q;  // Request taken, waiting for hit or refill.
    logic look_q;  // Read data below belongs to this cycle.

    logic   rd_valid_q;
    tag_t   rd_tag_q;
    tag_t   look_tag_q;
    block_t rd_block_q;

    index_t req_index;
    logic   accept;
    logic   hit;

    assign req_index = bus_i.addr[OFFSET_W+2 +: INDEX_W];
    assign accept    = bus_i.req && !busy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            look_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            look_q <= accept;

            if (accept) begin
                busy_q <= 1'b1;
            end else if (bus_i.ready) begin
                busy_q <= 1'b0;  // Hit or refill delivered.
            end

            if (bus_i.invalidate) begin
                valid_q <= '0;
            end else if (fill_i.we) begin
                valid_q[fill_i.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i.we) begin
            tag_mem[fill_i.index]  <= fill_i.tag;
            data_mem[fill_i.index] <= fill_i.block;
        end

        if (accept) begin
            rd_valid_q <= valid_q[req_index];
            rd_tag_q   <= tag_mem[req_index];
            rd_block_q <= data_mem[req_index];
            look_tag_q <= bus_i.addr[31 -: TAG_W];
        end
    end

    assign hit = rd_valid_q && (rd_tag_q == look_tag_q);

    assign bus_i.hit_ready  = look_q && hit;
    assign bus_i.miss       = look_q && !hit;  // Hands the request to the refill.
    assign bus_i.hit_bundle = rd_block_q;

    // A miss must not coincide with any answer, from this array or from the refill.
    no_ready_on_miss: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(bus_i.ready && bus_i.miss));

endmodule : icache_array

//--- verilog/refill_controller.sv
module refill_controller import icache_cfg_pkg::*, icache_types_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    bundle_if.refill     bus_io,
    line_write_if.source fill_o,

    // Wishbone classic master.
    output logic [31:0] wb_adr_o,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_fill
    } state_t;

    state_t      state_q;
    logic        cyc_q;
    logic        stb_q;
    offset_t     word_q;   // Word being read.
    line_write_t line_q;   // Line under construction.

    logic last_word;
    logic start;

    assign start     = (state_q == st_idle) && bus_io.miss;
    assign last_word = (word_q == offset_t'(BLOCK_WORDS - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
            word_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (bus_io.miss) begin
                        state_q <= st_read;
                        cyc_q   <= 1'b1;
                        stb_q   <= 1'b1;
                        word_q  <= '0;  // Start at the block base.
                    end
                end

                st_read: begin
                    if (stb_q && wb_ack_i) begin
                        // Drop the cycle for one clock between words.
                        cyc_q <= 1'b0;
                        stb_q <= 1'b0;
                        if (last_word) begin
                            state_q <= st_fill;
                        end else begin
                            word_q <= word_q + 1'b1;
                        end
                    end else if (!cyc_q) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                    end
                end

                st_fill: begin
                    state_q <= st_idle;  // Write and answer take one cycle.
                end

                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            line_q.tag   <= bus_io.addr[31 -: TAG_W];
            line_q.index <= bus_io.addr[OFFSET_W+2 +: INDEX_W];
        end
        if (stb_q && wb_ack_i) begin
            line_q.block[word_q] <= wb_dat_i;
        end
    end

    assign wb_adr_o = {line_q.tag, line_q.index, word_q, 2'b00};
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = stb_q;
    assign wb_we_o  = 1'b0;  // Read only port.

    assign fill_o.we    = (state_q == st_fill);
    assign fill_o.index = line_q.index;
    assign fill_o.tag   = line_q.tag;
    assign fill_o.block = line_q.block;

    // Block goes to the sequencer in the same cycle as the array write.
    assign bus_io.fill_ready  = (state_q == st_fill);
    assign bus_io.fill_bundle = line_q.block;

    // Stray acks outside a strobed cycle would be lost.
    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_i |-> wb_cyc_o && wb_stb_o);

    adr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o));

endmodule : refill_controller

//--- verilog/icache_top.sv
module icache_top import icache_types_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Core fetch port.
    input  logic        fetch_i,
    input  logic [31:0] fetch_addr_i,
    input  logic        invalidate_i,
    output instr_t      instr_o,
    output logic        valid_o,
    output logic        stall_o,

    // Wishbone classic master.
    output logic [31:0] wb_adr_o,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i
);

    bundle_if     bundle_bus ();
    line_write_if fill_bus ();

    fetch_sequencer u_seq (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .fetch_i      ( fetch_i      ),
        .fetch_addr_i ( fetch_addr_i ),
        .invalidate_i ( invalidate_i ),
        .instr_o      ( instr_o      ),
        .valid_o      ( valid_o      ),
        .stall_o      ( stall_o      ),
        .bus_o        ( bundle_bus   )
    );

    icache_array u_array (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .bus_i   ( bundle_bus ),
        .fill_i  ( fill_bus   )
    );

    refill_controller u_refill (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .bus_io   ( bundle_bus ),
        .fill_o   ( fill_bus   ),
        .wb_adr_o ( wb_adr_o   ),
        .wb_cyc_o ( wb_cyc_o   ),
        .wb_stb_o ( wb_stb_o   ),
        .wb_we_o  ( wb_we_o    ),
        .wb_dat_i ( wb_dat_i   ),
        .wb_ack_i ( wb_ack_i   )
    );

endmodule : icache_top

//--- tests/wb_mem_model.sv
module wb_mem_model import icache_types_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] wb_adr_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    input  logic        next_epoch_i,  // Single cycle, changes every stored word.
    output int          txn_count_o,
    output block_t      burst_o        // Words of the latest block read, in bus order.
);

    timeunit 1ns;
    timeprecision 1ps;

    int      epoch_q;
    int      wait_q;   // Cycles left before the ack.
    logic    busy_q;
    offset_t beat_q;   // Position of the next read within its burst.
    integer  seed;

    initial seed = 32'h7a45_9e2f;

    // Contents: the address xored with a pattern that moves with the epoch.
    function automatic logic [31:0] word_at(input logic [31:0] adr, input int epoch);
        return adr ^ (32'h6c8e_9cf5 ^ (epoch * 32'h9e37_79b9));
    endfunction

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o    <= 1'b0;
            wb_dat_o    <= '0;
            busy_q      <= 1'b0;
            wait_q      <= 0;
            beat_q      <= '0;
            epoch_q     <= 0;
            txn_count_o <= 0;
        end else begin
            if (next_epoch_i) begin
                epoch_q <= epoch_q + 1;
            end

            if (wb_ack_o) begin
                wb_ack_o <= 1'b0;  // Master drops stb on this edge.
                busy_q   <= 1'b0;
            end else if (wb_cyc_i && wb_stb_i) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= {$random(seed)} % 4;
                end else if (wait_q != 0) begin
                    wait_q <= wait_q - 1;
                end else begin
                    wb_ack_o        <= 1'b1;
                    wb_dat_o        <= word_at(wb_adr_i, epoch_q);
                    burst_o[beat_q] <= word_at(wb_adr_i, epoch_q);
                    beat_q          <= beat_q + 1'b1;
                    txn_count_o     <= txn_count_o + 1;
                end
            end
        end
    end

endmodule : wb_mem_model

//--- tests/tb_icache.sv
module tb_icache import icache_cfg_pkg::*, icache_types_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_FETCHES    = 600;
    localparam int          TIMEOUT_CYCLES = NUM_FETCHES * 40;
    localparam logic [31:0] WIN_BASE       = 32'h0002_0000;  // 4 KB window with four tags per line.

    logic        clk_i;
    logic        rst_n_i;
    logic        fetch_i;
    logic [31:0] fetch_addr_i;
    logic        invalidate_i;
    instr_t      instr_o;
    logic        valid_o;
    logic        stall_o;
    logic [31:0] wb_adr_o;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic        wb_we_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    logic        next_epoch;
    int          txn_count;
    block_t      burst;

    // Reference model of the resident lines and the sequencer buffer.
    logic        res_valid [LINES];
    tag_t        res_tag [LINES];
    logic [31:0] prev_addr;
    int          buf_cnt;
    int          epoch;
    int          fail_cnt;
    int          cycle_cnt = 0;
    integer      seed;

    icache_top u_dut (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .fetch_i      ( fetch_i      ),
        .fetch_addr_i ( fetch_addr_i ),
        .invalidate_i ( invalidate_i ),
        .instr_o      ( instr_o      ),
        .valid_o      ( valid_o      ),
        .stall_o      ( stall_o      ),
        .wb_adr_o     ( wb_adr_o     ),
        .wb_cyc_o     ( wb_cyc_o     ),
        .wb_stb_o     ( wb_stb_o     ),
        .wb_we_o      ( wb_we_o      ),
        .wb_dat_i     ( wb_dat_i     ),
        .wb_ack_i     ( wb_ack_i     )
    );

    wb_mem_model u_mem (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .wb_adr_i     ( wb_adr_o   ),
        .wb_cyc_i     ( wb_cyc_o   ),
        .wb_stb_i     ( wb_stb_o   ),
        .wb_dat_o     ( wb_dat_i   ),
        .wb_ack_o     ( wb_ack_i   ),
        .next_epoch_i ( next_epoch ),
        .txn_count_o  ( txn_count  ),
        .burst_o      ( burst      )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic fail_now(input string msg);
        fail_cnt++;
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            fail_now($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    // Memory contents as the address xored with an epoch dependent pattern.
    function automatic instr_t expected_word(input logic [31:0] addr, input int ep);
        return addr ^ (32'h6c8e_9cf5 ^ (ep * 32'h9e37_79b9));
    endfunction

    task automatic fetch_one(input logic [31:0] addr);
        int          lat;
        int          txn_before;
        logic        seq;
        logic        resident;
        index_t      idx;
        tag_t        tag;
        offset_t     off;
        logic [31:0] base;
        idx      = addr[OFFSET_W+2 +: INDEX_W];
        tag      = addr[31 -: TAG_W];
        off      = addr[2 +: OFFSET_W];
        base     = addr & ~32'(BLOCK_BYTES - 1);
        seq      = (buf_cnt != 0) && (addr == prev_addr + 32'd4);
        resident = res_valid[idx] && (res_tag[idx] == tag);

        @(negedge clk_i);
        fetch_i      = 1'b1;
        fetch_addr_i = addr;
        txn_before   = txn_count;
        lat          = 0;
        do begin
            @(posedge clk_i);
            lat++;
            if (valid_o !== 1'b1 && stall_o !== 1'b1) begin
                fail_now("stall_o is low while a fetch waits for valid_o.");
            end
        end while (valid_o !== 1'b1);

        check_instr("instr_o", instr_o, expected_word(addr, epoch));
        if (seq) begin
            check_count("valid_o latency", lat, 1);  // Same cycle as fetch_i.
            check_count("wb transactions", txn_count - txn_before, 0);
            buf_cnt--;
        end else begin
            if (resident) begin
                check_count("valid_o latency", lat, 3);
                check_count("wb transactions", txn_count - txn_before, 0);
            end else begin
                check_count("wb transactions", txn_count - txn_before, BLOCK_WORDS);
                // Data identifies the address, so this also checks the read order.
                for (int w = 0; w < BLOCK_WORDS; w++) begin
                    check_instr($sformatf("wb_dat_i word %0d", w), burst[w],
                                expected_word(base + 32'(4 * w), epoch));
                end
                res_valid[idx] = 1'b1;
                res_tag[idx]   = tag;
            end
            buf_cnt = BLOCK_WORDS - 1 - int'(off);
        end
        prev_addr = addr;
    endtask

    task automatic flush_cache();
        @(negedge clk_i);
        fetch_i      = 1'b0;
        invalidate_i = 1'b1;
        next_epoch   = 1'b1;
        @(negedge clk_i);
        invalidate_i = 1'b0;
        next_epoch   = 1'b0;
        epoch++;
        buf_cnt = 0;
        for (int i = 0; i < LINES; i++) begin
            res_valid[i] = 1'b0;
        end
    endtask

    task automatic idle_cycles(input int n);
        @(negedge clk_i);
        fetch_i = 1'b0;
        repeat (n) @(negedge clk_i);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_now($sformatf("Timeout after %0d cycles, the fetch stream did not finish.",
                               TIMEOUT_CYCLES));
        end
        if (fetch_i === 1'b0 && stall_o !== 1'b0) begin
            fail_now("stall_o is high while fetch_i is low.");
        end
        if (wb_we_o !== 1'b0) begin
            fail_now("wb_we_o rose on the read only Wishbone port.");
        end
    end

    initial begin
        logic [31:0] addr;
        int          run_left;
        seed         = 32'h7a45_9e2f;
        rst_n_i      = 1'b0;
        fetch_i      = 1'b0;
        fetch_addr_i = '0;
        invalidate_i = 1'b0;
        next_epoch   = 1'b0;
        fail_cnt     = 0;
        epoch        = 0;
        buf_cnt      = 0;
        prev_addr    = '0;
        run_left     = 0;
        addr         = WIN_BASE;
        for (int i = 0; i < LINES; i++) begin
            res_valid[i] = 1'b0;
        end

        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(posedge clk_i);
        if ({valid_o, stall_o, wb_cyc_o, wb_stb_o} !== 4'b0000) begin
            fail_now("Core or Wishbone outputs are active after reset.");
        end

        // Sequential runs broken by random jumps inside the window.
        for (int n = 0; n < NUM_FETCHES; n++) begin
            if (run_left == 0) begin
                addr     = WIN_BASE | ({$random(seed)} & 32'h0000_0ffc);
                run_left = 1 + {$random(seed)} % 8;
            end
            fetch_one(addr);
            run_left--;
            addr = WIN_BASE | ((addr + 32'd4) & 32'h0000_0ffc);
            if (n % 100 == 50) begin
                flush_cache();
                fetch_one(prev_addr);  // The same address now refills with new data.
            end else if ({$random(seed)} % 8 == 0) begin
                idle_cycles(1 + {$random(seed)} % 3);
            end
        end

        @(negedge clk_i);
        fetch_i = 1'b0;
        repeat (4) @(posedge clk_i);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_icache

//--- verilog.f
verilog/icache_cfg_pkg.sv
verilog/icache_types_pkg.sv
verilog/icache_if.sv
verilog/fetch_sequencer.sv
verilog/icache_array.sv
verilog/refill_controller.sv
verilog/icache_top.sv
tests/wb_mem_model.sv
tests/tb_icache.sv
